// ==== rtl/vc_link_cfg.svh ====
`ifndef VC_LINK_CFG_SVH
`define VC_LINK_CFG_SVH

// --------------------
// Link dimensions
// --------------------

`define VC_CHANNELS   4   // Virtual channels sharing the link

// Payload bits per flit, head and tail bits come on top
`define VC_DATA_WIDTH 16

`define VC_FIFO_DEPTH 4   // Receive FIFO entries per channel

`endif

// ==== rtl/vc_link_pkg.sv ====
`include "vc_link_cfg.svh"

package vc_link_pkg;

  // --------------------
  // Flit layout
  // --------------------

  typedef logic [`VC_DATA_WIDTH-1:0] vc_data_t;

  // Head is the top bit, tail sits just below it
  typedef logic [`VC_DATA_WIDTH+1:0] vc_flit_t;

  typedef logic [`VC_CHANNELS-1:0]         vc_mask_t;   // One bit per channel
  typedef logic [$clog2(`VC_CHANNELS)-1:0] vc_index_t;

  typedef enum logic {
    arb_idle,
    arb_locked
  } arb_state_t;

endpackage

// ==== rtl/vc_flit_if.sv ====
`timescale 1ns/100ps

interface vc_flit_if;
  import vc_link_pkg::*;

  vc_mask_t valid;      // At most one bit high, owned by the granted channel
  vc_mask_t ready;
  vc_mask_t vc_ready;   // Channel can take a new packet
  vc_flit_t flit;

  modport sender (
    output valid,
    output flit,
    input  ready,
    input  vc_ready
  );

  modport receiver (
    input  valid,
    input  flit,
    output ready,
    output vc_ready
  );

endinterface

// ==== rtl/vc_rr_arbiter.sv ====
`timescale 1ns/100ps
`include "vc_link_cfg.svh"

module vc_rr_arbiter (
  input  logic                  clk,
  input  logic                  reset,
  input  vc_link_pkg::vc_mask_t request,
  input  logic                  free,
  output vc_link_pkg::vc_mask_t grant
);
  import vc_link_pkg::*;

  localparam int CHANNELS = `VC_CHANNELS;

  arb_state_t state;
  vc_index_t  ptr;          // First channel to look at when idle
  vc_index_t  winner;
  vc_mask_t   idle_grant;
  vc_mask_t   held_grant;

  // --------------------
  // Grant selection
  // --------------------

  // Walk backwards from the far end so the last match is the closest to ptr
  always_comb begin
    int k;
    idle_grant = '0;
    for (int i = CHANNELS - 1; i >= 0; i--) begin
      k = (int'(ptr) + i) % CHANNELS;
      if (request[k]) begin
        idle_grant = vc_mask_t'(1) << k;
      end
    end
  end

  // Once locked the request is ignored, the owner keeps the link to its tail
  assign grant = (state == arb_locked) ? held_grant : idle_grant;

  always_comb begin
    winner = '0;
    for (int i = 0; i < CHANNELS; i++) begin
      if (grant[i]) begin
        winner = vc_index_t'(i);
      end
    end
  end

  // --------------------
  // Lock and priority
  // --------------------

  // A grant made while idle is accepted in that cycle, because a request needs
  // vc_ready and vc_ready implies room in the receive FIFO
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= arb_idle;
      ptr   <= '0;
    end else begin
      case (state)
        arb_idle: begin
          if ((grant != '0) && !free) begin
            state <= arb_locked;
          end
        end
        arb_locked: begin
          if (free) begin
            state <= arb_idle;
          end
        end
        default: state <= arb_idle;
      endcase

      if (free) begin   // Next search starts just past the channel that finished
        ptr <= (int'(winner) == CHANNELS - 1) ? '0 : winner + vc_index_t'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == arb_idle) begin
      held_grant <= idle_grant;
    end
  end

endmodule

// ==== rtl/vc_flit_mux.sv ====
`timescale 1ns/100ps
`include "vc_link_cfg.svh"

module vc_flit_mux (
  input  logic                                      clk,
  input  logic                                      reset,
  input  vc_link_pkg::vc_mask_t                     in_valid,
  input  vc_link_pkg::vc_flit_t [`VC_CHANNELS-1:0]  in_flit,
  output vc_link_pkg::vc_mask_t                     in_ready,
  vc_flit_if.sender                                 link
);
  import vc_link_pkg::*;

  localparam int CHANNELS = `VC_CHANNELS;

  vc_mask_t request;
  vc_mask_t grant;
  vc_flit_t sel_flit;
  logic     free;

  // --------------------
  // Arbitration
  // --------------------

  // New packets only go to channels with at least two free slots downstream
  assign request = in_valid & link.vc_ready;

  vc_rr_arbiter u_arbiter (
    .clk     (clk),
    .reset   (reset),
    .request (request),
    .free    (free),
    .grant   (grant)
  );

  // --------------------
  // Link side
  // --------------------

  assign link.valid = in_valid & grant;
  assign in_ready   = link.ready & grant;   // Only the owner sees ready

  // Grant is one-hot, so an AND-OR select is enough
  always_comb begin
    sel_flit = '0;
    for (int i = 0; i < CHANNELS; i++) begin
      sel_flit |= in_flit[i] & {$bits(vc_flit_t){grant[i]}};
    end
  end

  assign link.flit = sel_flit;

  // Tail accepted on the link releases the arbiter
  assign free = (|(link.valid & link.ready)) && sel_flit[`VC_DATA_WIDTH];

endmodule

// ==== rtl/vc_flit_fifo.sv ====
`timescale 1ns/100ps

module vc_flit_fifo #(
  parameter int DEPTH = 4
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  push,
  input  vc_link_pkg::vc_flit_t push_flit,
  input  logic                  pop,
  output vc_link_pkg::vc_flit_t pop_flit,
  output logic                  empty,
  output logic                  full,
  output logic                  almost_full
);
  import vc_link_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  vc_flit_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  // --------------------
  // Pointers and level
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin   // Wrap by compare so any depth works
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_flit;
    end
  end

  assign pop_flit    = mem[rd_ptr];
  assign empty       = (count == '0);
  assign full        = (count == CNT_W'(DEPTH));
  assign almost_full = (count >= CNT_W'(DEPTH - 1));   // Fewer than two slots left

endmodule

// ==== rtl/vc_flit_demux.sv ====
`timescale 1ns/100ps
`include "vc_link_cfg.svh"

module vc_flit_demux (
  input  logic                                      clk,
  input  logic                                      reset,
  vc_flit_if.receiver                               link,
  output vc_link_pkg::vc_mask_t                     out_valid,
  output vc_link_pkg::vc_flit_t [`VC_CHANNELS-1:0]  out_flit,
  input  vc_link_pkg::vc_mask_t                     out_ready
);
  import vc_link_pkg::*;

  localparam int CHANNELS = `VC_CHANNELS;

  vc_mask_t empty;
  vc_mask_t full;
  vc_mask_t almost_full;

  // --------------------
  // Per channel storage
  // --------------------

  for (genvar k = 0; k < CHANNELS; k++) begin : g_vc
    vc_flit_fifo #(
      .DEPTH (`VC_FIFO_DEPTH)
    ) u_fifo (
      .clk         (clk),
      .reset       (reset),
      .push        (link.valid[k] & link.ready[k]),
      .push_flit   (link.flit),
      .pop         (out_valid[k] & out_ready[k]),
      .pop_flit    (out_flit[k]),
      .empty       (empty[k]),
      .full        (full[k]),
      .almost_full (almost_full[k])
    );
  end

  assign out_valid = ~empty;

  // Accept flits while there is room, only offer new packets with some slack
  assign link.ready    = ~full;
  assign link.vc_ready = ~almost_full;

endmodule

// ==== rtl/vc_link_top.sv ====
`timescale 1ns/100ps
`include "vc_link_cfg.svh"

module vc_link_top (
  input  logic                                      clk,
  input  logic                                      reset,

  // Sending side, one valid/ready pair per channel
  input  vc_link_pkg::vc_mask_t                     in_valid,
  input  vc_link_pkg::vc_flit_t [`VC_CHANNELS-1:0]  in_flit,
  output vc_link_pkg::vc_mask_t                     in_ready,

  // Receiving side
  output vc_link_pkg::vc_mask_t                     out_valid,
  output vc_link_pkg::vc_flit_t [`VC_CHANNELS-1:0]  out_flit,
  input  vc_link_pkg::vc_mask_t                     out_ready
);

  // --------------------
  // Shared flit bus
  // --------------------

  vc_flit_if link_if ();

  vc_flit_mux u_mux (
    .clk      (clk),
    .reset    (reset),
    .in_valid (in_valid),
    .in_flit  (in_flit),
    .in_ready (in_ready),
    .link     (link_if.sender)
  );

  vc_flit_demux u_demux (
    .clk       (clk),
    .reset     (reset),
    .link      (link_if.receiver),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

endmodule

// ==== test/tb_clock_gen.sv ====
`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int PERIOD       = 8,    // ns
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // Released on a rising edge so the DUT sees a clean synchronous reset
  initial begin
    reset = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== test/vc_link_asserts.sv ====
`timescale 1ns/100ps

module vc_link_asserts (
  input logic                  clk,
  input logic                  reset,
  input vc_link_pkg::vc_mask_t in_valid,
  input vc_link_pkg::vc_mask_t in_ready,
  input vc_link_pkg::vc_mask_t link_valid,   // Valid bits as the mux drives them
  input vc_link_pkg::vc_mask_t grant,
  input logic                  free
);

  // --------------------
  // Link protocol
  // --------------------

  a_single_valid: assert property (@(posedge clk) disable iff (reset) $onehot0(link_valid))
    else $error("More than one VC valid on the link: %b", link_valid);

  a_grant_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(grant))
    else $error("Arbiter grant is not one-hot: %b", grant);

  // A flit on the link stays there until the receiver takes it
  a_valid_held: assert property (@(posedge clk) disable iff (reset)
    ((link_valid != '0) && ((link_valid & in_ready) == '0))
      |=> ((in_valid & $past(grant)) == $past(link_valid)))
    else $error("Granted VC dropped its valid before the flit was accepted");

  // Without a tail the owner keeps the link
  a_grant_locked: assert property (@(posedge clk) disable iff (reset)
    ((grant != '0) && !free) |=> (grant == $past(grant)))
    else $error("Grant changed in the middle of a packet: %b", grant);

endmodule

bind vc_flit_mux vc_link_asserts u_asserts (
  .clk        (clk),
  .reset      (reset),
  .in_valid   (in_valid),
  .in_ready   (in_ready),
  .link_valid (link.valid),
  .grant      (grant),
  .free       (free)
);

// ==== test/vc_link_tb.sv ====
`timescale 1ns/100ps
`include "vc_link_cfg.svh"

module vc_link_tb;
  import vc_link_pkg::*;

  localparam int CHANNELS       = `VC_CHANNELS;
  localparam int DEPTH          = `VC_FIFO_DEPTH;
  localparam int TAIL_BIT       = `VC_DATA_WIDTH;
  localparam int PACKETS_PER_VC = 12;

  logic                             clk;
  logic                             reset;
  vc_mask_t                         in_valid;
  vc_flit_t [`VC_CHANNELS-1:0]      in_flit;
  vc_mask_t                         in_ready;
  vc_mask_t                         out_valid;
  vc_flit_t [`VC_CHANNELS-1:0]      out_flit;
  vc_mask_t                         out_ready;

  logic [31:0] rng_state = 32'd77;
  vc_flit_t    send_q [CHANNELS][$];     // Flits still to offer, per VC
  vc_flit_t    expect_q [CHANNELS][$];   // Accepted but not yet delivered
  int          sent_idx [CHANNELS];
  int          occ [CHANNELS];           // Model of each receive FIFO level
  int          locked_vc;                // -1 while the link is free
  int          rr_ptr;
  int          total_flits;
  int          delivered;
  int          cycles;
  int          limit;
  int          reset_edges;
  vc_mask_t    accepted;

  tb_clock_gen u_clock_gen (
    .clk   (clk),
    .reset (reset)
  );

  vc_link_top vc_link_top_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_flit   (in_flit),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_flit  (out_flit),
    .out_ready (out_ready)
  );

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
  endfunction

  task automatic fail_check(input string msg);
    $display("[ERROR] %0t ns: %s", $time, msg);
    $display("Test FAILED");
    $fatal(1);
  endtask

  // --------------------
  // Stimulus
  // --------------------

  task automatic build_packets();
    logic [31:0] r;
    int          len;
    total_flits = 0;
    for (int k = 0; k < CHANNELS; k++) begin
      for (int p = 0; p < PACKETS_PER_VC; p++) begin
        r   = next_random();
        len = int'(r[1:0]) + 1;
        for (int f = 0; f < len; f++) begin
          r = next_random();
          send_q[k].push_back({f == 0, f == len - 1, vc_data_t'(r)});
        end
        total_flits += len;
      end
    end
  endtask

  task automatic drive_inputs();
    vc_mask_t                    next_valid;
    vc_mask_t                    next_ready;
    vc_flit_t [`VC_CHANNELS-1:0] next_flit;
    logic [31:0]                 r;
    next_valid = in_valid;
    next_flit  = in_flit;
    for (int k = 0; k < CHANNELS; k++) begin
      if (accepted[k]) sent_idx[k]++;
      if (!in_valid[k] || accepted[k]) begin   // An offered flit waits for ready
        r = next_random();
        next_valid[k] = (sent_idx[k] < send_q[k].size()) && (r[1:0] != 2'b00);
        if (next_valid[k]) next_flit[k] = send_q[k][sent_idx[k]];
      end
      next_ready[k] = (next_random() % 32'd10) >= 32'd3;   // About 30% stall
    end
    in_valid  <= next_valid;
    in_flit   <= next_flit;
    out_ready <= next_ready;
  endtask

  // --------------------
  // Model and checks
  // --------------------

  task automatic check_reset_state();
    assert ((out_valid == '0) && (in_ready == '0))
      else fail_check($sformatf("out_valid %b, in_ready %b around reset", out_valid, in_ready));
  endtask

  task automatic check_and_update();
    vc_mask_t exp_ready;
    int       j;
    logic     found;
    exp_ready = '0;
    found     = 1'b0;
    if (locked_vc >= 0) begin   // Owner sees ready whenever its FIFO has room
      exp_ready[locked_vc] = occ[locked_vc] < DEPTH;
      assert ((in_ready & ~(vc_mask_t'(1) << locked_vc)) == '0)
        else fail_check($sformatf("VC %0d owns the link, in_ready %b", locked_vc, in_ready));
    end else begin
      for (int i = 0; i < CHANNELS; i++) begin
        j = (rr_ptr + i) % CHANNELS;
        if (!found && in_valid[j] && (DEPTH - occ[j] >= 2)) begin
          exp_ready[j] = 1'b1;
          found        = 1'b1;
        end
      end
    end
    assert ($onehot0(in_ready))
      else fail_check($sformatf("in_ready %b has more than one bit set", in_ready));
    assert (in_ready == exp_ready)
      else fail_check($sformatf("in_ready %b, expected %b", in_ready, exp_ready));

    for (int k = 0; k < CHANNELS; k++) begin
      // Also catches a flit that shows up in the cycle it was accepted
      assert (out_valid[k] == (occ[k] != 0))
        else fail_check($sformatf("VC %0d out_valid %b with %0d flits stored",
                                  k, out_valid[k], occ[k]));
      if (occ[k] == DEPTH) begin
        assert (!in_ready[k]) else fail_check($sformatf("VC %0d ready while full", k));
      end
      if (out_valid[k] && out_ready[k]) begin
        assert ((expect_q[k].size() != 0) && (out_flit[k] == expect_q[k][0]))
          else fail_check($sformatf("VC %0d delivered %h, expected %h",
                                    k, out_flit[k], expect_q[k][0]));
        void'(expect_q[k].pop_front());
        occ[k]--;
        delivered++;
      end
      accepted[k] = in_valid[k] && in_ready[k];
      if (accepted[k]) begin
        expect_q[k].push_back(in_flit[k]);
        occ[k]++;
        if (in_flit[k][TAIL_BIT]) begin
          locked_vc = -1;
          rr_ptr    = (k + 1) % CHANNELS;
        end else begin
          locked_vc = k;
        end
      end
      assert (occ[k] <= DEPTH)
        else fail_check($sformatf("VC %0d holds %0d flits, above depth", k, occ[k]));
    end
  endtask

  // --------------------
  // Main sequence
  // --------------------

  initial begin
    in_valid  = '0;
    in_flit   = '0;
    out_ready = '0;
    accepted  = '0;
    locked_vc = -1;
    rr_ptr    = 0;
    delivered = 0;
    cycles    = 0;
    reset_edges = 0;
    for (int k = 0; k < CHANNELS; k++) begin
      sent_idx[k] = 0;
      occ[k]      = 0;
    end
    build_packets();
    limit = 40 * total_flits + 200;

    while (delivered < total_flits) begin
      @(posedge clk);
      cycles++;
      if (cycles > limit) begin
        $display("Run timed out after %0d cycles, %0d of %0d flits delivered",
                 cycles, delivered, total_flits);
        $display("Test FAILED");
        $fatal(1);
      end
      if (reset) begin
        if (reset_edges > 0) check_reset_state();   // First edge only clears the flops
        reset_edges++;
      end else begin
        if (reset_edges > 0) begin
          check_reset_state();
          reset_edges = 0;
        end
        check_and_update();
        drive_inputs();
      end
    end

    @(posedge clk);   // A stray extra flit would show up on out_valid here
    for (int k = 0; k < CHANNELS; k++) begin
      assert ((expect_q[k].size() == 0) && !out_valid[k])
        else fail_check($sformatf("VC %0d still has %0d flits queued, out_valid %b",
                                  k, expect_q[k].size(), out_valid[k]));
    end
    $display("Test OK");
    $finish;
  end

endmodule

// ==== vc_link.f ====
+incdir+rtl
rtl/vc_link_pkg.sv
rtl/vc_flit_if.sv
rtl/vc_rr_arbiter.sv
rtl/vc_flit_mux.sv
rtl/vc_flit_fifo.sv
rtl/vc_flit_demux.sv
rtl/vc_link_top.sv
test/tb_clock_gen.sv
test/vc_link_asserts.sv
test/vc_link_tb.sv

// ==== Makefile ====
# Verilator build and run for the virtual channel link

VERILATOR ?= verilator
TOP       ?= vc_link_tb
FILELIST  ?= vc_link.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test OK

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard rtl/*.sv rtl/*.svh test/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }
	@echo "Simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
